// ==== flist.f ====
src/tlbPkg.sv
src/tlbRequestStage.sv
src/tlbEntryStore.sv
src/tlbWayMatch.sv
src/tlbResponseStage.sv
src/tlbMmu.sv
tests/tlbMmuTb.sv

// ==== run.sh ====
#!/bin/sh
# compile the DUT and testbench from flist.f, then run; any failing check exits non-zero
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -j 0 --top-module tlbMmuTb -f flist.f -o tlbSim \
	&& ./obj_dir/tlbSim \
	|| { echo "simulation did not pass"; exit 1; }

// ==== tests/tlbMmuTb.sv ====
// directed testbench for the translation buffer top level, built from flist.f by run.sh
`timescale 1ns/1ps

module tlbMmuTb;

	// about 120 cycles of tests, rounded up
	localparam int testCycles = 160;

	logic clock;
	logic rstN;
	logic [tlbPkg::addrWidth-1:0] inAddr;
	logic [tlbPkg::lineWidth-1:0] inData;
	logic [tlbPkg::opmWidth-1:0] inOpm;
	logic [tlbPkg::seqWidth-1:0] inSeq;
	logic [tlbPkg::lineWidth-1:0] ldtlbWord;
	logic [tlbPkg::mmcrWidth-1:0] mmcr;
	logic hold;
	logic [tlbPkg::addrWidth-1:0] outAddr;
	logic [tlbPkg::lineWidth-1:0] outData;
	logic [tlbPkg::opmWidth-1:0] outOpm;
	logic [tlbPkg::seqWidth-1:0] outSeq;
	logic [tlbPkg::excWidth-1:0] excCode;
	logic [tlbPkg::addrWidth-1:0] excAddr;
	logic [31:0] rngState = 32'h417d_2a55;
	logic [tlbPkg::lineWidth-1:0] expData;
	logic [tlbPkg::seqWidth-1:0] expSeq;
	tlbPkg::pageSize curSize;

	tlbMmu u_dut (
		.clock(clock), .rstN(rstN), .inAddr(inAddr), .inData(inData), .inOpm(inOpm),
		.inSeq(inSeq), .ldtlbWord(ldtlbWord), .mmcr(mmcr), .hold(hold),
		.outAddr(outAddr), .outData(outData), .outOpm(outOpm), .outSeq(outSeq),
		.excCode(excCode), .excAddr(excAddr)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial
	begin
		#(testCycles * 10 * 2);
		abortRun("watchdog expired before the tests finished");
	end

	task automatic abortRun(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkAddr(input string name, input logic [tlbPkg::addrWidth-1:0] got,
			input logic [tlbPkg::addrWidth-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic checkLine(input string name, input logic [tlbPkg::lineWidth-1:0] got,
			input logic [tlbPkg::lineWidth-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic checkOpm(input string name, input logic [tlbPkg::opmWidth-1:0] got,
			input logic [tlbPkg::opmWidth-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic checkSeq(input string name, input logic [tlbPkg::seqWidth-1:0] got,
			input logic [tlbPkg::seqWidth-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic checkExc(input string name, input logic [tlbPkg::excWidth-1:0] got,
			input logic [tlbPkg::excWidth-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] randWord();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic logic [tlbPkg::addrWidth-1:0] randAddr(input logic [3:0] region);
		logic [31:0] hi;
		logic [31:0] lo;
		hi = randWord();
		lo = randWord();
		return {region, hi, lo[11:0]};
	endfunction

	function automatic logic [tlbPkg::opmWidth-1:0] opWord(input tlbPkg::tlbOp op);
		return {8'h00, op};
	endfunction

	function automatic logic [tlbPkg::lineWidth-1:0] makeEntry(
			input logic [tlbPkg::addrWidth-1:0] va, input logic [tlbPkg::vpnWidth-1:0] ppn,
			input logic [tlbPkg::asidWidth-1:0] asid);
		logic [tlbPkg::lineWidth-1:0] w;
		w = '0;
		w[tlbPkg::entValidBit] = 1'b1;
		w[tlbPkg::entPpnLo +: tlbPkg::vpnWidth] = ppn;
		w[tlbPkg::entAsidLo +: tlbPkg::asidWidth] = asid;
		w[tlbPkg::entVaLo +: tlbPkg::addrWidth] = va;
		return w;
	endfunction

	// page bits from the entry, everything under the page size from the request
	function automatic logic [tlbPkg::addrWidth-1:0] expPhys(
			input logic [tlbPkg::vpnWidth-1:0] ppn, input logic [tlbPkg::addrWidth-1:0] va);
		logic [tlbPkg::addrWidth-1:0] keep;
		logic [tlbPkg::addrWidth-1:0] pa;
		case (curSize)
			tlbPkg::pg4k: keep = 48'h0000_0000_0FFF;
			tlbPkg::pg16k: keep = 48'h0000_0000_3FFF;
			default: keep = 48'h0000_0000_FFFF;
		endcase
		pa = ({ppn, 12'h000} & ~keep) | (va & keep);
		if (pa[47:44] == 4'h0)
			pa[47:44] = tlbPkg::regionPhys;
		return pa;
	endfunction

	task automatic driveReq(input logic [tlbPkg::addrWidth-1:0] addr, input tlbPkg::tlbOp op);
		inAddr = addr;
		inOpm = opWord(op);
		inSeq = inSeq + 16'd1;
		inData = {randWord(), randWord(), randWord(), randWord()};
		expSeq = inSeq;
		expData = inData;
	endtask

	// fixed latency, outputs are settled two falling edges later
	task automatic issue(input logic [tlbPkg::addrWidth-1:0] addr, input tlbPkg::tlbOp op);
		driveReq(addr, op);
		@(negedge clock);
		inOpm = opWord(tlbPkg::opIdle);
		@(negedge clock);
	endtask

	task automatic loadEntry(input logic [tlbPkg::addrWidth-1:0] va,
			input logic [tlbPkg::vpnWidth-1:0] ppn, input logic [tlbPkg::asidWidth-1:0] asid);
		ldtlbWord = makeEntry(va, ppn, asid);
		issue('0, tlbPkg::opLdtlb);
	endtask

	// pipeline idles three cycles before the control word moves
	task automatic setControl(input logic enable, input tlbPkg::pageSize size,
			input logic [tlbPkg::asidWidth-1:0] asid);
		inOpm = opWord(tlbPkg::opIdle);
		repeat (3) @(negedge clock);
		mmcr = '0;
		mmcr[tlbPkg::mmcrEnableBit] = enable;
		mmcr[tlbPkg::mmcrPg64kBit] = (size == tlbPkg::pg64k);
		mmcr[tlbPkg::mmcrPg16kBit] = (size == tlbPkg::pg16k);
		mmcr[tlbPkg::mmcrAsidLo +: tlbPkg::asidWidth] = asid;
		curSize = size;
	endtask

	task automatic checkResult(input logic [tlbPkg::addrWidth-1:0] addr,
			input logic [tlbPkg::opmWidth-1:0] opm, input logic [tlbPkg::excWidth-1:0] exc);
		checkAddr("outAddr", outAddr, addr);
		checkLine("outData", outData, expData);
		checkOpm("outOpm", outOpm, opm);
		checkSeq("outSeq", outSeq, expSeq);
		checkExc("excCode", excCode, exc);
	endtask

	task automatic checkHit(input logic [tlbPkg::addrWidth-1:0] va,
			input logic [tlbPkg::vpnWidth-1:0] ppn, input tlbPkg::tlbOp op);
		checkResult(expPhys(ppn, va), opWord(op), '0);
	endtask

	task automatic checkMiss(input logic [tlbPkg::addrWidth-1:0] va, input tlbPkg::tlbOp op);
		logic [tlbPkg::opmWidth-1:0] opm;
		opm = opWord(op);
		opm[11:8] = tlbPkg::flagMiss;
		checkResult({tlbPkg::faultPage, va[11:0]}, opm, tlbPkg::excTlbMiss);
		checkAddr("excAddr", excAddr, va);
	endtask

	task automatic testBypass();
		logic [tlbPkg::addrWidth-1:0] a;
		logic [tlbPkg::opmWidth-1:0] opm;
		setControl(1'b0, tlbPkg::pg4k, 16'h0005);
		a = randAddr(4'h3);
		issue(a, tlbPkg::opLoad);
		checkResult(a, opWord(tlbPkg::opLoad), '0);
		a = randAddr(4'h7);
		issue(a, tlbPkg::opStore);
		checkResult(a, opWord(tlbPkg::opStore), '0);
		setControl(1'b1, tlbPkg::pg4k, 16'h0005);
		a = randAddr(tlbPkg::regionPhys);
		issue(a, tlbPkg::opLoad);
		checkResult(a, opWord(tlbPkg::opLoad), '0);
		a = randAddr(tlbPkg::regionIo);
		issue(a, tlbPkg::opStore);
		checkResult(a, opWord(tlbPkg::opStore), '0);
		// uncached region gets the flag on the way out
		a = randAddr(tlbPkg::regionPhysUncached);
		opm = opWord(tlbPkg::opPrefetch);
		opm[tlbPkg::flagUncachedBit] = 1'b1;
		issue(a, tlbPkg::opPrefetch);
		checkResult(a, opm, '0);
	endtask

	task automatic testMiss();
		logic [tlbPkg::addrWidth-1:0] a;
		setControl(1'b1, tlbPkg::pg4k, 16'h0005);
		a = randAddr(4'h2);
		issue(a, tlbPkg::opLoad);
		checkMiss(a, tlbPkg::opLoad);
	endtask

	task automatic hitOneSize(input tlbPkg::pageSize size, input logic [3:0] nibble);
		logic [tlbPkg::addrWidth-1:0] va;
		logic [tlbPkg::vpnWidth-1:0] ppn;
		setControl(1'b1, size, 16'h0005);
		va = randAddr(4'h1);
		ppn = {nibble, randWord()};
		loadEntry(va, ppn, 16'h0005);
		issue(va, tlbPkg::opLoad);
		checkHit(va, ppn, tlbPkg::opLoad);
		// only bits below the page size change
		case (size)
			tlbPkg::pg4k: va[11:0] = ~va[11:0];
			tlbPkg::pg16k: va[13:0] = ~va[13:0];
			default: va[15:0] = ~va[15:0];
		endcase
		issue(va, tlbPkg::opStore);
		checkHit(va, ppn, tlbPkg::opStore);
	endtask

	task automatic testReplace();
		logic [tlbPkg::addrWidth-1:0] base;
		logic [tlbPkg::addrWidth-1:0] va [5];
		logic [tlbPkg::vpnWidth-1:0] ppn [5];
		setControl(1'b1, tlbPkg::pg4k, 16'h0005);
		base = randAddr(4'h2);
		// bits 17..12 fixed, so all five land in one set
		for (int i = 0; i < 5; i++)
		begin
			va[i] = base;
			va[i][21:18] = 4'(i);
			ppn[i] = {4'h0, randWord()};
			loadEntry(va[i], ppn[i], 16'h0005);
		end
		issue(va[0], tlbPkg::opLoad);
		checkMiss(va[0], tlbPkg::opLoad);
		issue(va[1], tlbPkg::opLoad);
		checkHit(va[1], ppn[1], tlbPkg::opLoad);
		issue(va[4], tlbPkg::opStore);
		checkHit(va[4], ppn[4], tlbPkg::opStore);
		ppn[0] = {4'h5, randWord()};
		loadEntry(va[4], ppn[0], 16'h0005);
		issue(va[4], tlbPkg::opLoad);
		checkHit(va[4], ppn[0], tlbPkg::opLoad);
		setControl(1'b1, tlbPkg::pg4k, 16'h0006);
		issue(va[4], tlbPkg::opLoad);
		checkMiss(va[4], tlbPkg::opLoad);
	endtask

	task automatic testInvalidate();
		logic [tlbPkg::addrWidth-1:0] va;
		logic [tlbPkg::addrWidth-1:0] vb;
		logic [tlbPkg::vpnWidth-1:0] ppn;
		setControl(1'b1, tlbPkg::pg4k, 16'h0005);
		va = randAddr(4'h4);
		vb = randAddr(4'h8);
		ppn = {4'h0, randWord()};
		loadEntry(va, ppn, 16'h0005);
		loadEntry(vb, {4'h9, randWord()}, 16'h0005);
		issue(va, tlbPkg::opLoad);
		checkHit(va, ppn, tlbPkg::opLoad);
		issue('0, tlbPkg::opInvtlb);
		issue(va, tlbPkg::opLoad);
		checkMiss(va, tlbPkg::opLoad);
		issue(vb, tlbPkg::opStore);
		checkMiss(vb, tlbPkg::opStore);
		loadEntry(va, ppn, 16'h0005);
		issue(va, tlbPkg::opPrefetch);
		checkHit(va, ppn, tlbPkg::opPrefetch);
	endtask

	task automatic testHold();
		logic [tlbPkg::addrWidth-1:0] va;
		logic [tlbPkg::addrWidth-1:0] vb;
		logic [tlbPkg::vpnWidth-1:0] ppn;
		logic [tlbPkg::lineWidth-1:0] dataA;
		logic [tlbPkg::lineWidth-1:0] dataB;
		logic [tlbPkg::seqWidth-1:0] seqA;
		logic [tlbPkg::seqWidth-1:0] seqB;
		setControl(1'b1, tlbPkg::pg16k, 16'h0005);
		va = randAddr(4'h6);
		vb = randAddr(4'h5);
		ppn = {4'h0, randWord()};
		loadEntry(va, ppn, 16'h0005);
		driveReq(va, tlbPkg::opLoad);
		dataA = expData;
		seqA = expSeq;
		@(negedge clock);
		driveReq(vb, tlbPkg::opStore);
		@(negedge clock);
		inOpm = opWord(tlbPkg::opIdle);
		hold = 1'b1;
		dataB = expData;
		seqB = expSeq;
		expData = dataA;
		expSeq = seqA;
		// first request sits at the outputs, second in the first stage
		repeat (4)
		begin
			checkHit(va, ppn, tlbPkg::opLoad);
			@(negedge clock);
		end
		checkHit(va, ppn, tlbPkg::opLoad);
		hold = 1'b0;
		@(negedge clock);
		expData = dataB;
		expSeq = seqB;
		checkMiss(vb, tlbPkg::opStore);
	endtask

	initial
	begin
		rstN = 1'b0;
		hold = 1'b0;
		inAddr = '0;
		inData = '0;
		inOpm = '0;
		inSeq = '0;
		ldtlbWord = '0;
		mmcr = '0;
		expData = '0;
		expSeq = '0;
		curSize = tlbPkg::pg4k;
		repeat (2) @(negedge clock);
		rstN = 1'b1;
		testBypass();
		// store is still empty here
		testMiss();
		hitOneSize(tlbPkg::pg4k, 4'h0);
		hitOneSize(tlbPkg::pg16k, 4'h0);
		hitOneSize(tlbPkg::pg64k, 4'h3);
		testReplace();
		testInvalidate();
		testHold();
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== src/tlbMmu.sv ====
// top level of the translation buffer between the L1 cache and the memory ring
`timescale 1ns/1ps

module tlbMmu (
	input  logic clock,
	input  logic rstN,
	input  logic [tlbPkg::addrWidth-1:0] inAddr,
	input  logic [tlbPkg::lineWidth-1:0] inData,
	input  logic [tlbPkg::opmWidth-1:0] inOpm,
	input  logic [tlbPkg::seqWidth-1:0] inSeq,
	input  logic [tlbPkg::lineWidth-1:0] ldtlbWord,
	input  logic [tlbPkg::mmcrWidth-1:0] mmcr,
	input  logic hold,
	output logic [tlbPkg::addrWidth-1:0] outAddr,
	output logic [tlbPkg::lineWidth-1:0] outData,
	output logic [tlbPkg::opmWidth-1:0] outOpm,
	output logic [tlbPkg::seqWidth-1:0] outSeq,
	output logic [tlbPkg::excWidth-1:0] excCode,
	output logic [tlbPkg::addrWidth-1:0] excAddr
);

	logic [tlbPkg::setBits-1:0] readIndex;
	logic [tlbPkg::setBits-1:0] stIndex;
	logic [tlbPkg::addrWidth-1:0] stAddr;
	logic [tlbPkg::lineWidth-1:0] stData;
	logic [tlbPkg::opmWidth-1:0] stOpm;
	logic [tlbPkg::seqWidth-1:0] stSeq;
	logic [tlbPkg::lineWidth-1:0] stLdtlbWord;
	logic stLoad;
	logic stInvalidate;
	logic stTranslate;
	tlbPkg::pageSize stPageSize;
	logic [tlbPkg::asidWidth-1:0] stAsid;
	logic [tlbPkg::wayCount-1:0][tlbPkg::vpnWidth-1:0] wayVpn;
	logic [tlbPkg::wayCount-1:0][tlbPkg::vpnWidth-1:0] wayPpn;
	logic [tlbPkg::wayCount-1:0][tlbPkg::asidWidth-1:0] wayAsid;
	logic [tlbPkg::wayCount-1:0] wayLive;
	logic hit;
	logic [tlbPkg::addrWidth-1:0] physAddr;

	tlbRequestStage uReq (
		.clock(clock), .rstN(rstN), .hold(hold),
		.inAddr(inAddr), .inData(inData), .inOpm(inOpm), .inSeq(inSeq),
		.ldtlbWord(ldtlbWord), .mmcr(mmcr),
		.readIndex(readIndex), .stIndex(stIndex), .stAddr(stAddr), .stData(stData),
		.stOpm(stOpm), .stSeq(stSeq), .stLdtlbWord(stLdtlbWord), .stLoad(stLoad),
		.stInvalidate(stInvalidate), .stTranslate(stTranslate),
		.stPageSize(stPageSize), .stAsid(stAsid)
	);

	// store read runs alongside the request stage
	tlbEntryStore uStore (
		.clock(clock), .rstN(rstN), .hold(hold),
		.readIndex(readIndex), .stIndex(stIndex), .stLoad(stLoad),
		.stInvalidate(stInvalidate), .stLdtlbWord(stLdtlbWord),
		.wayVpn(wayVpn), .wayPpn(wayPpn), .wayAsid(wayAsid), .wayLive(wayLive)
	);

	tlbWayMatch uMatch (
		.stAddr(stAddr), .stAsid(stAsid), .stPageSize(stPageSize),
		.wayVpn(wayVpn), .wayPpn(wayPpn), .wayAsid(wayAsid), .wayLive(wayLive),
		.hit(hit), .physAddr(physAddr)
	);

	tlbResponseStage uResp (
		.clock(clock), .rstN(rstN), .hold(hold),
		.stAddr(stAddr), .stData(stData), .stOpm(stOpm), .stSeq(stSeq),
		.stTranslate(stTranslate), .hit(hit), .physAddr(physAddr),
		.outAddr(outAddr), .outData(outData), .outOpm(outOpm), .outSeq(outSeq),
		.excCode(excCode), .excAddr(excAddr)
	);

endmodule

// ==== src/tlbResponseStage.sv ====
// second pipeline stage, resolves hit, miss or bypass and registers the outgoing request
`timescale 1ns/1ps

module tlbResponseStage (
	input  logic clock,
	input  logic rstN,
	input  logic hold,
	input  logic [tlbPkg::addrWidth-1:0] stAddr,
	input  logic [tlbPkg::lineWidth-1:0] stData,
	input  logic [tlbPkg::opmWidth-1:0] stOpm,
	input  logic [tlbPkg::seqWidth-1:0] stSeq,
	input  logic stTranslate,
	input  logic hit,
	input  logic [tlbPkg::addrWidth-1:0] physAddr,
	output logic [tlbPkg::addrWidth-1:0] outAddr,
	output logic [tlbPkg::lineWidth-1:0] outData,
	output logic [tlbPkg::opmWidth-1:0] outOpm,
	output logic [tlbPkg::seqWidth-1:0] outSeq,
	output logic [tlbPkg::excWidth-1:0] excCode,
	output logic [tlbPkg::addrWidth-1:0] excAddr
);

	logic [3:0] region;
	logic miss;
	logic [tlbPkg::addrWidth-1:0] nxtAddr;
	logic [tlbPkg::opmWidth-1:0] nxtOpm;
	logic [tlbPkg::excWidth-1:0] nxtExc;
	logic [tlbPkg::addrWidth-1:0] nxtExcAddr;

	assign region = stAddr[tlbPkg::regionLo +: 4];
	assign miss = stTranslate && !hit;

	always_comb
	begin
		nxtAddr = stAddr;
		nxtOpm = stOpm;
		nxtExc = '0;
		nxtExcAddr = '0;

		// uncached physical region is flagged for the ring
		if (region == tlbPkg::regionPhysUncached)
			nxtOpm[tlbPkg::flagUncachedBit] = 1'b1;

		if (miss)
		begin
			// redirect to the fault page, keep the offset
			nxtAddr = {tlbPkg::faultPage, stAddr[tlbPkg::pageShift-1:0]};
			nxtOpm[tlbPkg::flagLo +: 4] = tlbPkg::flagMiss;
			nxtExc = tlbPkg::excTlbMiss;
			nxtExcAddr = stAddr;
		end
		else if (stTranslate)
		begin
			nxtAddr = physAddr;
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			outOpm <= '0;
			outSeq <= '0;
			excCode <= '0;
		end
		else if (!hold)
		begin
			outOpm <= nxtOpm;
			outSeq <= stSeq;
			excCode <= nxtExc;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			outAddr <= nxtAddr;
			outData <= stData;
			excAddr <= nxtExcAddr;
		end
	end

	// any raised exception is a miss and must carry the miss flag downstream
	assert property (@(posedge clock) disable iff (!rstN)
		(excCode != '0) |-> (outOpm[tlbPkg::flagLo +: 4] == tlbPkg::flagMiss));

endmodule

// ==== src/tlbWayMatch.sv ====
// combinational 4-way compare of the read set against the staged request
`timescale 1ns/1ps

module tlbWayMatch (
	input  logic [tlbPkg::addrWidth-1:0] stAddr,
	input  logic [tlbPkg::asidWidth-1:0] stAsid,
	input  tlbPkg::pageSize stPageSize,
	input  logic [tlbPkg::wayCount-1:0][tlbPkg::vpnWidth-1:0] wayVpn,
	input  logic [tlbPkg::wayCount-1:0][tlbPkg::vpnWidth-1:0] wayPpn,
	input  logic [tlbPkg::wayCount-1:0][tlbPkg::asidWidth-1:0] wayAsid,
	input  logic [tlbPkg::wayCount-1:0] wayLive,
	output logic hit,
	output logic [tlbPkg::addrWidth-1:0] physAddr
);

	logic [tlbPkg::vpnWidth-1:0] stVpn;
	logic [tlbPkg::wayCount-1:0] highEq;
	logic [tlbPkg::wayCount-1:0] midEq;
	logic [tlbPkg::wayCount-1:0] lowEq;
	logic [tlbPkg::wayCount-1:0] wayHit;
	logic [tlbPkg::vpnWidth-1:0] pickPpn;

	assign stVpn = stAddr[tlbPkg::addrWidth-1:tlbPkg::pageShift];

	// high part always compares, bits 15..14 and 13..12 depend on page size
	always_comb
	begin
		for (int w = 0; w < tlbPkg::wayCount; w++)
		begin
			highEq[w] = wayVpn[w][tlbPkg::vpnWidth-1:tlbPkg::pg64kShift-tlbPkg::pageShift] ==
				stVpn[tlbPkg::vpnWidth-1:tlbPkg::pg64kShift-tlbPkg::pageShift];
			midEq[w] = (stPageSize == tlbPkg::pg64k) ||
				(wayVpn[w][tlbPkg::pg64kShift-tlbPkg::pageShift-1:
					tlbPkg::pg16kShift-tlbPkg::pageShift] ==
				stVpn[tlbPkg::pg64kShift-tlbPkg::pageShift-1:
					tlbPkg::pg16kShift-tlbPkg::pageShift]);
			lowEq[w] = (stPageSize != tlbPkg::pg4k) ||
				(wayVpn[w][tlbPkg::pg16kShift-tlbPkg::pageShift-1:0] ==
				stVpn[tlbPkg::pg16kShift-tlbPkg::pageShift-1:0]);
			wayHit[w] = wayLive[w] && (wayAsid[w] == stAsid) &&
				highEq[w] && midEq[w] && lowEq[w];
		end
	end

	// lowest way wins, so scan from the top down
	always_comb
	begin
		hit = 1'b0;
		pickPpn = '0;
		for (int w = tlbPkg::wayCount - 1; w >= 0; w--)
		begin
			if (wayHit[w])
			begin
				hit = 1'b1;
				pickPpn = wayPpn[w];
			end
		end
	end

	always_comb
	begin
		physAddr = {pickPpn, stAddr[tlbPkg::pageShift-1:0]};
		// large pages keep the low virtual page bits
		if (stPageSize != tlbPkg::pg4k)
			physAddr[tlbPkg::pg16kShift-1:tlbPkg::pageShift] =
				stAddr[tlbPkg::pg16kShift-1:tlbPkg::pageShift];
		if (stPageSize == tlbPkg::pg64k)
			physAddr[tlbPkg::pg64kShift-1:tlbPkg::pg16kShift] =
				stAddr[tlbPkg::pg64kShift-1:tlbPkg::pg16kShift];
		if (physAddr[tlbPkg::regionLo +: 4] == 4'h0)
			physAddr[tlbPkg::regionLo +: 4] = tlbPkg::regionPhys;
	end

endmodule

// ==== src/tlbEntryStore.sv ====
// four-way entry arrays of the translation buffer with a registered read and a shifting insert
`timescale 1ns/1ps

module tlbEntryStore (
	input  logic clock,
	input  logic rstN,
	input  logic hold,
	input  logic [tlbPkg::setBits-1:0] readIndex,
	input  logic [tlbPkg::setBits-1:0] stIndex,
	input  logic stLoad,
	input  logic stInvalidate,
	input  logic [tlbPkg::lineWidth-1:0] stLdtlbWord,
	output logic [tlbPkg::wayCount-1:0][tlbPkg::vpnWidth-1:0] wayVpn,
	output logic [tlbPkg::wayCount-1:0][tlbPkg::vpnWidth-1:0] wayPpn,
	output logic [tlbPkg::wayCount-1:0][tlbPkg::asidWidth-1:0] wayAsid,
	output logic [tlbPkg::wayCount-1:0] wayLive
);

	logic [tlbPkg::vpnWidth-1:0] vpnMem [tlbPkg::wayCount][tlbPkg::setCount];
	logic [tlbPkg::vpnWidth-1:0] ppnMem [tlbPkg::wayCount][tlbPkg::setCount];
	logic [tlbPkg::asidWidth-1:0] asidMem [tlbPkg::wayCount][tlbPkg::setCount];
	logic [tlbPkg::epochWidth-1:0] epochMem [tlbPkg::wayCount][tlbPkg::setCount];
	logic [tlbPkg::setCount-1:0] validMem [tlbPkg::wayCount];
	logic [tlbPkg::setCount-1:0] loadedBits [tlbPkg::wayCount];
	logic [tlbPkg::epochWidth-1:0] epoch;
	logic [tlbPkg::wayCount-1:0] rdLoaded;
	logic [tlbPkg::wayCount-1:0] rdValid;
	logic [tlbPkg::epochWidth-1:0] rdEpoch [tlbPkg::wayCount];
	logic doWrite;

	// the insert moves with the LDTLB leaving the first stage
	assign doWrite = stLoad && !hold;

	// new entry goes to way 0, older ones shift back and way 3 drops out
	always_ff @(posedge clock)
	begin
		if (doWrite)
		begin
			for (int w = tlbPkg::wayCount - 1; w > 0; w--)
			begin
				vpnMem[w][stIndex] <= vpnMem[w-1][stIndex];
				ppnMem[w][stIndex] <= ppnMem[w-1][stIndex];
				asidMem[w][stIndex] <= asidMem[w-1][stIndex];
				epochMem[w][stIndex] <= epochMem[w-1][stIndex];
				validMem[w][stIndex] <= validMem[w-1][stIndex];
			end
			vpnMem[0][stIndex] <=
				stLdtlbWord[tlbPkg::entVaLo + tlbPkg::pageShift +: tlbPkg::vpnWidth];
			ppnMem[0][stIndex] <= stLdtlbWord[tlbPkg::entPpnLo +: tlbPkg::vpnWidth];
			asidMem[0][stIndex] <= stLdtlbWord[tlbPkg::entAsidLo +: tlbPkg::asidWidth];
			epochMem[0][stIndex] <= epoch;
			validMem[0][stIndex] <= stLdtlbWord[tlbPkg::entValidBit];
		end
	end

	// loaded bits follow the same shift
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int w = 0; w < tlbPkg::wayCount; w++)
				loadedBits[w] <= '0;
		end
		else if (doWrite)
		begin
			for (int w = tlbPkg::wayCount - 1; w > 0; w--)
				loadedBits[w][stIndex] <= loadedBits[w-1][stIndex];
			loadedBits[0][stIndex] <= 1'b1;
		end
	end

	// INVTLB retires every stored entry at once
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			epoch <= '0;
		else if (stInvalidate && !hold)
			epoch <= epoch + 1'b1;
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			rdLoaded <= '0;
		else if (!hold)
		begin
			for (int w = 0; w < tlbPkg::wayCount; w++)
				rdLoaded[w] <= loadedBits[w][readIndex];
		end
	end

	// set read, lines up with the request stage
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			for (int w = 0; w < tlbPkg::wayCount; w++)
			begin
				wayVpn[w] <= vpnMem[w][readIndex];
				wayPpn[w] <= ppnMem[w][readIndex];
				wayAsid[w] <= asidMem[w][readIndex];
				rdEpoch[w] <= epochMem[w][readIndex];
				rdValid[w] <= validMem[w][readIndex];
			end
		end
	end

	always_comb
	begin
		for (int w = 0; w < tlbPkg::wayCount; w++)
			wayLive[w] = rdLoaded[w] && rdValid[w] && (rdEpoch[w] == epoch);
	end

	// a held pipeline must not lose an INVTLB
	assert property (@(posedge clock) disable iff (!rstN) hold |=> $stable(epoch));

endmodule

// ==== src/tlbRequestStage.sv ====
// first pipeline stage of the translation buffer, decodes a request and picks its set
`timescale 1ns/1ps

module tlbRequestStage (
	input  logic clock,
	input  logic rstN,
	input  logic hold,
	input  logic [tlbPkg::addrWidth-1:0] inAddr,
	input  logic [tlbPkg::lineWidth-1:0] inData,
	input  logic [tlbPkg::opmWidth-1:0] inOpm,
	input  logic [tlbPkg::seqWidth-1:0] inSeq,
	input  logic [tlbPkg::lineWidth-1:0] ldtlbWord,
	input  logic [tlbPkg::mmcrWidth-1:0] mmcr,
	output logic [tlbPkg::setBits-1:0] readIndex,
	output logic [tlbPkg::setBits-1:0] stIndex,
	output logic [tlbPkg::addrWidth-1:0] stAddr,
	output logic [tlbPkg::lineWidth-1:0] stData,
	output logic [tlbPkg::opmWidth-1:0] stOpm,
	output logic [tlbPkg::seqWidth-1:0] stSeq,
	output logic [tlbPkg::lineWidth-1:0] stLdtlbWord,
	output logic stLoad,
	output logic stInvalidate,
	output logic stTranslate,
	output tlbPkg::pageSize stPageSize,
	output logic [tlbPkg::asidWidth-1:0] stAsid
);

	tlbPkg::tlbOp inOp;
	tlbPkg::pageSize pgSel;
	logic [tlbPkg::addrWidth-1:0] lookupAddr;
	logic [3:0] region;
	logic isAccess;
	logic translate;

	assign inOp = tlbPkg::tlbOp'(inOpm[tlbPkg::opCodeWidth-1:0]);
	assign region = inAddr[tlbPkg::regionLo +: 4];
	assign isAccess = (inOp == tlbPkg::opLoad) || (inOp == tlbPkg::opStore) ||
		(inOp == tlbPkg::opPrefetch);

	// physical, uncached and I/O regions bypass the lookup
	assign translate = mmcr[tlbPkg::mmcrEnableBit] && isAccess &&
		(region != tlbPkg::regionPhys) && (region != tlbPkg::regionPhysUncached) &&
		(region != tlbPkg::regionIo);

	// 64K wins when both size bits are set
	always_comb
	begin
		if (mmcr[tlbPkg::mmcrPg64kBit])
			pgSel = tlbPkg::pg64k;
		else if (mmcr[tlbPkg::mmcrPg16kBit])
			pgSel = tlbPkg::pg16k;
		else
			pgSel = tlbPkg::pg4k;
	end

	// LDTLB indexes by the virtual address held in its entry word
	assign lookupAddr = (inOp == tlbPkg::opLdtlb) ?
		ldtlbWord[tlbPkg::entVaLo +: tlbPkg::addrWidth] : inAddr;

	always_comb
	begin
		case (pgSel)
			tlbPkg::pg64k:
				readIndex = lookupAddr[tlbPkg::pg64kShift +: tlbPkg::setBits];
			tlbPkg::pg16k:
				readIndex = {lookupAddr[tlbPkg::pg64kShift-1:tlbPkg::pg16kShift],
					lookupAddr[tlbPkg::pg64kShift +: tlbPkg::setBits-2]};
			default:
				readIndex = {lookupAddr[tlbPkg::pg64kShift-1:tlbPkg::pageShift],
					lookupAddr[tlbPkg::pg64kShift +: tlbPkg::setBits-4]};
		endcase
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			stOpm <= '0;
			stSeq <= '0;
			stLoad <= 1'b0;
			stInvalidate <= 1'b0;
			stTranslate <= 1'b0;
		end
		else if (!hold)
		begin
			stOpm <= inOpm;
			stSeq <= inSeq;
			stLoad <= (inOp == tlbPkg::opLdtlb);
			stInvalidate <= (inOp == tlbPkg::opInvtlb);
			stTranslate <= translate;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			stAddr <= inAddr;
			stData <= inData;
			stLdtlbWord <= ldtlbWord;
			stIndex <= readIndex;
			stPageSize <= pgSel;
			stAsid <= mmcr[tlbPkg::mmcrAsidLo +: tlbPkg::asidWidth];
		end
	end

	// a staged op is an insert or a flush, never both
	assert property (@(posedge clock) disable iff (!rstN) !(stLoad && stInvalidate));

endmodule

// ==== src/tlbPkg.sv ====
// shared widths, field positions and encodings of the translation buffer, compiled first
package tlbPkg;

	// address and page geometry
	localparam int addrWidth = 48;
	localparam int pageShift = 12;
	localparam int pg16kShift = 14;
	localparam int pg64kShift = 16;
	localparam int vpnWidth = addrWidth - pageShift;
	localparam int regionLo = addrWidth - 4;

	// 4-way set associative store
	localparam int setBits = 6;
	localparam int setCount = 1 << setBits;
	localparam int wayCount = 4;
	localparam int epochWidth = 8;

	// request and response fields
	localparam int asidWidth = 16;
	localparam int lineWidth = 128;
	localparam int opmWidth = 16;
	localparam int seqWidth = 16;
	localparam int excWidth = 16;
	localparam int mmcrWidth = 64;
	localparam int opCodeWidth = 8;
	localparam int flagLo = 8;

	// LDTLB entry word, low bit of each field
	localparam int entValidBit = 0;
	localparam int entPpnLo = 12;
	localparam int entAsidLo = 48;
	localparam int entVaLo = 64;

	// control word bits
	localparam int mmcrEnableBit = 0;
	localparam int mmcrPg64kBit = 4;
	localparam int mmcrPg16kBit = 5;
	localparam int mmcrAsidLo = 48;

	// top address nibble of the untranslated regions
	localparam logic [3:0] regionPhys = 4'hC;
	localparam logic [3:0] regionPhysUncached = 4'hD;
	localparam logic [3:0] regionIo = 4'hF;

	// page a missed request is redirected to, offset comes from the request
	localparam logic [vpnWidth-1:0] faultPage = {regionPhys, 32'h0000_0010};

	localparam logic [3:0] flagMiss = 4'hF;
	localparam int flagUncachedBit = 11;
	localparam logic [excWidth-1:0] excTlbMiss = 16'hA001;

	// low byte of the operation word
	typedef enum logic [opCodeWidth-1:0] {
		opIdle = 8'h00,
		opLoad = 8'h21,
		opPrefetch = 8'h29,
		opStore = 8'h31,
		opLdtlb = 8'h41,
		opInvtlb = 8'h42
	} tlbOp;

	typedef enum logic [1:0] {pg4k, pg16k, pg64k} pageSize;

endpackage
